// ==== common/pokey_defs.svh ====
// POKEY I/O sizing constants fixed by the chip register map
`ifndef POKEY_DEFS_SVH
`define POKEY_DEFS_SVH

// last line of a pot scan, also the max pot value
`define POT_LINES 228

// paddle inputs
`define NUM_POTS 8

// key counter width, 64 keys in the matrix
`define KEY_BITS 6

`endif

// ==== common/pokey_pkg.sv ====
// POKEY I/O package with the register map and keyboard FSM encodings
package pokey_pkg;

    // cpu register addresses in the 4-bit space
    typedef enum logic [3:0] {
        POT0   = 4'h0,  // paddle 0 count
        POT1   = 4'h1,
        POT2   = 4'h2,
        POT3   = 4'h3,
        POT4   = 4'h4,
        POT5   = 4'h5,
        POT6   = 4'h6,
        POT7   = 4'h7,  // paddle 7 count
        ALLPOT = 4'h8,  // pots still counting
        KBCODE = 4'h9,  // last accepted key code
        POTGO  = 4'hB,  // write only, starts a pot scan
        SKSTAT = 4'hF   // read side of 0xF, key status
    } pokey_reg_e;

    // write side of 0xF shares the address with SKSTAT
    localparam pokey_reg_e SKCTL = SKSTAT;

    // keyboard debounce states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,  // nothing held
        COMPARE = 2'd1,  // code captured, waiting one full pass
        HELD    = 2'd2,  // key accepted
        RELEASE = 2'd3   // one up pass seen
    } key_state_e;

endpackage

// ==== keyscan/key_scanner.sv ====
// POKEY keyboard scanner, matrix counter with two-pass debounce and keycode latch
`timescale 1ns/1ps
`include "pokey_defs.svh"

module key_scanner
    import pokey_pkg::*;
(
    input  logic                 o2,
    input  logic                 reset,
    input  logic                 key_en,
    input  logic                 kr1_l,       // low when addressed key is down
    output logic [`KEY_BITS-1:0] key_scan_l,  // inverted scan count to the matrix
    output logic [7:0]           kbcode,
    output logic                 key_down,
    output logic                 key_irq
);

    logic [`KEY_BITS-1:0] scan_ctr;
    logic [`KEY_BITS-1:0] compare_latch;   // key under debounce
    key_state_e           state;
    logic                 at_compare;      // scan is back at the latched key
    logic                 key_seen;        // addressed key is down

    assign key_scan_l = ~scan_ctr;
    assign at_compare = (scan_ctr == compare_latch);
    assign key_seen   = ~kr1_l;

    // status covers held and the first up pass
    assign key_down = (state == HELD) || (state == RELEASE);

    // scan counter, 64 cycles per pass
    always_ff @(posedge o2) begin
        if (reset) begin
            scan_ctr <= '0;
        end else if (key_en) begin
            scan_ctr <= scan_ctr + 1'b1;   // wraps after 63
        end
    end

    // capture the count of the first down key seen
    always_ff @(posedge o2) begin
        if (key_en && (state == IDLE) && key_seen) begin
            compare_latch <= scan_ctr;
        end
    end

    // debounce FSM
    always_ff @(posedge o2) begin
        if (reset) begin
            state   <= IDLE;
            kbcode  <= 8'h00;
            key_irq <= 1'b0;
        end else begin
            key_irq <= 1'b0;   // single cycle pulse
            if (key_en) begin
                case (state)
                    IDLE: begin
                        if (key_seen) begin
                            state <= COMPARE;   // latch loaded this cycle
                        end
                    end
                    COMPARE: begin
                        if (at_compare) begin
                            if (key_seen) begin
                                // same key down a full pass later
                                state   <= HELD;
                                kbcode  <= {{(8 - `KEY_BITS){1'b0}}, compare_latch};
                                key_irq <= 1'b1;
                            end else begin
                                state <= IDLE;   // bounce, no irq
                            end
                        end
                    end
                    HELD: begin
                        if (at_compare && !key_seen) begin
                            state <= RELEASE;
                        end
                    end
                    RELEASE: begin
                        if (at_compare) begin
                            // second up pass releases, down again goes back
                            state <= key_seen ? HELD : IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== potscan/pot_scanner.sv ====
// POKEY pot scanner, line counter with eight pot latches, ALLPOT and dump control
`timescale 1ns/1ps
`include "pokey_defs.svh"

module pot_scanner (
    input  logic                 o2,
    input  logic                 reset,
    input  logic                 potgo,       // start strobe from the write port
    input  logic                 line_tick,   // once per TV line
    input  logic [`NUM_POTS-1:0] pot_sync,
    output logic [7:0]           pot0,
    output logic [7:0]           pot1,
    output logic [7:0]           pot2,
    output logic [7:0]           pot3,
    output logic [7:0]           pot4,
    output logic [7:0]           pot5,
    output logic [7:0]           pot6,
    output logic [7:0]           pot7,
    output logic [`NUM_POTS-1:0] allpot,      // set while a pot is still counting
    output logic                 pot_dump     // high discharges the caps
);

    logic [7:0] pot_val [`NUM_POTS];
    logic [7:0] line_ctr;
    logic       scanning;
    logic       scan_end;

    assign scan_end = (line_ctr == 8'(`POT_LINES));

    // latched counts out to the read port
    assign pot0 = pot_val[0];
    assign pot1 = pot_val[1];
    assign pot2 = pot_val[2];
    assign pot3 = pot_val[3];
    assign pot4 = pot_val[4];
    assign pot5 = pot_val[5];
    assign pot6 = pot_val[6];
    assign pot7 = pot_val[7];

    always_ff @(posedge o2) begin
        if (reset) begin
            line_ctr <= 8'd0;
            scanning <= 1'b0;
            allpot   <= '0;
            pot_dump <= 1'b1;   // caps held empty until POTGO
            for (int i = 0; i < `NUM_POTS; i++) begin
                pot_val[i] <= 8'd0;
            end
        end else if (potgo) begin
            // fresh scan, release the caps
            line_ctr <= 8'd0;
            scanning <= 1'b1;
            allpot   <= '1;
            pot_dump <= 1'b0;
            for (int i = 0; i < `NUM_POTS; i++) begin
                pot_val[i] <= 8'd0;
            end
        end else if (scanning) begin
            if (scan_end) begin
                // slow pots take the max count
                for (int i = 0; i < `NUM_POTS; i++) begin
                    if (allpot[i]) begin
                        pot_val[i] <= 8'(`POT_LINES);
                    end
                end
                allpot   <= '0;
                scanning <= 1'b0;
                pot_dump <= 1'b1;
            end else if (line_tick) begin
                for (int i = 0; i < `NUM_POTS; i++) begin
                    if (pot_sync[i] && allpot[i]) begin
                        pot_val[i] <= line_ctr;   // first line seen high
                        allpot[i]  <= 1'b0;
                    end
                end
                line_ctr <= line_ctr + 8'd1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the POKEY I/O testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module pokey_io_tb \
    -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vpokey_io_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

// ==== sim/pokey_io_assertions.sv ====
// POKEY I/O protocol checks bound onto the top level ports
`timescale 1ns/1ps

module pokey_io_assertions (
    input logic o2,
    input logic reset,
    input logic rd,
    input logic rd_valid,
    input logic key_irq,
    input logic potgo,      // internal start strobe of the top
    input logic pot_dump
);

    // read data one cycle after every read strobe
    rd_valid_after_rd: assert property (
        @(posedge o2) disable iff (reset) rd |=> rd_valid
    ) else $error("rd_valid missing one cycle after rd");

    // and never without a read
    rd_valid_only_after_rd: assert property (
        @(posedge o2) disable iff (reset) !rd |=> !rd_valid
    ) else $error("rd_valid high without a read one cycle before");

    key_irq_single_cycle: assert property (
        @(posedge o2) disable iff (reset) key_irq |=> !key_irq
    ) else $error("key_irq high on two consecutive cycles");

    // caps released as the scan starts
    dump_off_after_potgo: assert property (
        @(posedge o2) disable iff (reset) potgo |=> !pot_dump
    ) else $error("pot_dump still high the cycle after potgo");

endmodule

bind pokey_io_top pokey_io_assertions assertions_i (
    .o2(o2),
    .reset(reset),
    .rd(rd),
    .rd_valid(rd_valid),
    .key_irq(key_irq),
    .potgo(potgo),
    .pot_dump(pot_dump)
);

// ==== sim/pokey_io_tb.sv ====
// POKEY I/O testbench with keyboard and paddle models, reference values and checks
`timescale 1ns/1ps
`include "pokey_defs.svh"

module pokey_io_tb
    import pokey_pkg::*;
();

    logic                 o2;
    logic                 reset;
    logic                 wr;
    logic                 rd;
    logic [3:0]           addr;
    logic [7:0]           wr_data;
    logic [7:0]           rd_data;
    logic                 rd_valid;
    logic                 key_irq;
    logic [`KEY_BITS-1:0] key_scan_l;
    logic                 kr1_l;
    logic [`NUM_POTS-1:0] pot_in;
    logic                 pot_dump;
    logic                 line_tick;

    logic                 key_held;               // keyboard model state
    logic [`KEY_BITS-1:0] key_code;
    logic                 paddle_run;             // paddle model control
    logic                 run_now;
    int                   tick_count;             // ticks since paddle start
    int                   tick_phase;
    int                   pot_line [`NUM_POTS];   // line each pot charges after
    logic [31:0]          lcg_state = 32'd15051;

    pokey_io_top dut_i (
        .o2(o2), .reset(reset), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .rd_valid(rd_valid), .key_irq(key_irq),
        .key_scan_l(key_scan_l), .kr1_l(kr1_l), .pot_in(pot_in),
        .pot_dump(pot_dump), .line_tick(line_tick)
    );

    initial begin
        o2 = 1'b0;
        forever #5 o2 = ~o2;   // 100 MHz
    end

    // keyboard matrix, return line low while the held key is addressed
    assign kr1_l = !(key_held && (~key_scan_l == key_code));

    // paddle model, one line_tick every 6 cycles, pots charge after their line
    initial begin
        line_tick  = 1'b0;
        pot_in     = '0;
        tick_count = 0;
        tick_phase = 0;
        forever begin
            @(posedge o2);
            run_now = paddle_run;   // sampled on the edge
            #1;
            line_tick = 1'b0;
            if (!run_now) begin
                tick_count = 0;
                tick_phase = 0;
            end else if (tick_phase == 5) begin
                line_tick  = 1'b1;
                tick_count = tick_count + 1;
                tick_phase = 0;
            end else begin
                tick_phase = tick_phase + 1;
            end
            for (int i = 0; i < `NUM_POTS; i++) begin
                pot_in[i] = run_now && (tick_count >= pot_line[i]);   // caps dumped when idle
            end
        end
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({16'd0, lcg_state[31:16]});   // upper bits, never negative
    endfunction

    // pot count saturates at the scan length
    function automatic int expected_pot(input int line);
        return (line >= `POT_LINES) ? `POT_LINES : line;
    endfunction

    // pots whose line has not been latched after ticks_done ticks
    function automatic int expected_allpot(input int ticks_done);
        int result;
        result = 0;
        for (int i = 0; i < `NUM_POTS; i++) begin
            if (pot_line[i] >= ticks_done) result = result | (1 << i);
        end
        return result;
    endfunction

    function automatic int expected_skstat(input logic down);
        return down ? 32'hFB : 32'hFF;   // bit 2 active low
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h",
                                    name, expected, actual));
        end
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        wr      = 1'b1;
        addr    = a;
        wr_data = d;
        @(posedge o2);
        #1;
        wr = 1'b0;
    endtask

    // single read, rd_valid must come exactly one cycle later
    task automatic read_reg(input logic [3:0] a, output logic [7:0] data);
        int waited;
        rd   = 1'b1;
        addr = a;
        @(posedge o2);
        #1;
        rd     = 1'b0;
        waited = 1;
        while (rd_valid !== 1'b1) begin
            if (waited >= 8) stop_on_error("timeout: rd_valid never came back for a read");
            @(posedge o2);
            #1;
            waited++;
        end
        check_value($sformatf("read latency addr %0d", a), 32'd1, 32'(waited));
        data = rd_data;
    endtask

    task automatic check_read(input string name, input logic [3:0] a, input int expected);
        logic [7:0] data;
        read_reg(a, data);
        check_value(name, 32'(expected), 32'(data));
    endtask

    task automatic wait_for_irq(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(posedge o2);
            #1;
            seen = key_irq;
            n++;
        end
    endtask

    task automatic wait_dump(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (pot_dump !== level) begin
            if (n >= limit) stop_on_error($sformatf("timeout: pot_dump stuck %s", what));
            @(posedge o2);
            #1;
            n++;
        end
    endtask

    // full POTGO scan, two pots never charge
    task automatic run_pot_scan(input string tag, input int idle_a, input int idle_b);
        int   mid;
        int   n;
        logic hit;
        for (int i = 0; i < `NUM_POTS; i++) pot_line[i] = lcg_next() % 240;
        pot_line[idle_a] = 1000;
        pot_line[idle_b] = 1000;
        mid = 40 + lcg_next() % 150;
        write_reg(POTGO, 8'h00);
        wait_dump(1'b0, 4, "high after POTGO");
        for (int i = 0; i < `NUM_POTS; i++) begin
            check_read($sformatf("%s pot%0d cleared", tag, i), 4'(i), 0);
        end
        check_read({tag, " allpot at start"}, ALLPOT, 32'hFF);
        paddle_run = 1'b1;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            if (n >= mid * 6 + 20) stop_on_error("timeout: paddle never reached mid-scan line");
            @(posedge o2);
            hit = (tick_count == mid);   // stable on the edge
            #1;
            n++;
        end
        check_read({tag, " allpot mid scan"}, ALLPOT, expected_allpot(mid));
        wait_dump(1'b1, 2000, "low, scan never ended");
        paddle_run = 1'b0;
        for (int i = 0; i < `NUM_POTS; i++) begin
            check_read($sformatf("%s pot%0d", tag, i), 4'(i), expected_pot(pot_line[i]));
        end
        check_read({tag, " allpot at end"}, ALLPOT, 0);
    endtask

    initial begin
        logic [3:0] reg_order [11];
        logic [3:0] tmp;
        logic [7:0] data;
        logic       seen;
        int         j;
        int         n;
        reset      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = 4'h0;
        wr_data    = 8'h00;
        key_held   = 1'b0;
        key_code   = '0;
        paddle_run = 1'b0;
        repeat (4) @(posedge o2);
        #1;
        reset = 1'b0;

        // reset values in a shuffled order
        for (int k = 0; k < 10; k++) reg_order[k] = 4'(k);
        reg_order[10] = SKSTAT;
        for (int k = 10; k > 0; k--) begin
            j = lcg_next() % (k + 1);
            tmp          = reg_order[k];
            reg_order[k] = reg_order[j];
            reg_order[j] = tmp;
        end
        for (int k = 0; k < 11; k++) begin
            check_read($sformatf("reset read addr %0d", reg_order[k]), reg_order[k],
                       (reg_order[k] == SKSTAT) ? expected_skstat(1'b0) : 0);
        end

        // key press accepted after two passes
        write_reg(SKCTL, 8'h02);
        key_code = 6'(lcg_next() % 64);
        key_held = 1'b1;
        wait_for_irq(200, seen);
        if (!seen) stop_on_error("timeout: no key interrupt within 200 cycles of a press");
        check_read("kbcode after press", KBCODE, int'(key_code));
        check_read("skstat key down", SKSTAT, expected_skstat(1'b1));

        // release needs two up passes, code stays
        key_held = 1'b0;
        n        = 0;
        data     = 8'h00;
        while (data[2] !== 1'b1) begin
            if (n >= 200) stop_on_error("timeout: key status still down after release");
            read_reg(SKSTAT, data);
            n++;
        end
        check_value("skstat after release", 32'(expected_skstat(1'b0)), 32'(data));
        check_read("kbcode kept after release", KBCODE, int'(key_code));

        // short bounce, key down only for the one cycle it is addressed
        key_code = 6'(lcg_next() % 64);
        n        = 0;
        while (~key_scan_l != key_code) begin
            if (n >= 64) stop_on_error("timeout: scanner never addressed the bounced key");
            @(posedge o2);
            #1;
            n++;
        end
        key_held = 1'b1;
        @(posedge o2);   // scanner sees the key on this edge only
        #1;
        key_held = 1'b0;
        wait_for_irq(200, seen);
        if (seen) stop_on_error("key interrupt raised for a press shorter than one pass");

        // scanning off
        write_reg(SKCTL, 8'h00);
        key_code = 6'(lcg_next() % 64);
        key_held = 1'b1;
        wait_for_irq(200, seen);
        key_held = 1'b0;
        if (seen) stop_on_error("key interrupt raised with keyboard scanning disabled");

        run_pot_scan("scan1", 2, 7);
        run_pot_scan("rescan", 0, 5);   // old counts must clear

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== source/pokey_bus_regs.sv ====
// POKEY input side, CPU write decode, key-scan enable and pot input sync
`timescale 1ns/1ps
`include "pokey_defs.svh"

module pokey_bus_regs
    import pokey_pkg::*;
(
    input  logic                 o2,
    input  logic                 reset,
    input  logic                 wr,
    input  logic [3:0]           addr,
    input  logic [7:0]           wr_data,
    input  logic [`NUM_POTS-1:0] pot_in,    // async paddle comparators
    output logic                 potgo,     // one cycle after a POTGO write
    output logic                 key_en,    // SKCTL bit 1
    output logic [`NUM_POTS-1:0] pot_sync
);

    pokey_reg_e             wr_reg;
    logic                   wr_potgo;
    logic                   wr_skctl;
    logic [`NUM_POTS-1:0]   pot_meta;   // first sync stage

    assign wr_reg   = pokey_reg_e'(addr);
    assign wr_potgo = wr && (wr_reg == POTGO);
    assign wr_skctl = wr && (wr_reg == SKCTL);

    // write strobes and control bits
    always_ff @(posedge o2) begin
        if (reset) begin
            potgo  <= 1'b0;
            key_en <= 1'b0;   // keyboard off until software enables it
        end else begin
            potgo <= wr_potgo;    // data value ignored on POTGO
            if (wr_skctl) begin
                key_en <= wr_data[1];
            end
        end
    end

    // two flop synchronizer for the paddle lines
    always_ff @(posedge o2) begin
        pot_meta <= pot_in;
        pot_sync <= pot_meta;     // clean level for pot_scanner
    end

endmodule

// ==== source/pokey_io_top.sv ====
// POKEY I/O top, write port, keyboard and pot scanners and read port
`timescale 1ns/1ps
`include "pokey_defs.svh"

module pokey_io_top (
    input  logic                 o2,
    input  logic                 reset,
    input  logic                 wr,
    input  logic                 rd,
    input  logic [3:0]           addr,
    input  logic [7:0]           wr_data,
    output logic [7:0]           rd_data,
    output logic                 rd_valid,
    output logic                 key_irq,
    output logic [`KEY_BITS-1:0] key_scan_l,
    input  logic                 kr1_l,
    input  logic [`NUM_POTS-1:0] pot_in,
    output logic                 pot_dump,
    input  logic                 line_tick
);

    logic                 potgo;
    logic                 key_en;
    logic [`NUM_POTS-1:0] pot_sync;
    logic [7:0]           kbcode;
    logic                 key_down;
    logic [7:0]           pot0, pot1, pot2, pot3;
    logic [7:0]           pot4, pot5, pot6, pot7;
    logic [`NUM_POTS-1:0] allpot;

    pokey_bus_regs bus_regs_i (
        .o2(o2), .reset(reset), .wr(wr), .addr(addr), .wr_data(wr_data),
        .pot_in(pot_in), .potgo(potgo), .key_en(key_en), .pot_sync(pot_sync)
    );

    key_scanner key_scanner_i (
        .o2(o2), .reset(reset), .key_en(key_en), .kr1_l(kr1_l),
        .key_scan_l(key_scan_l), .kbcode(kbcode), .key_down(key_down), .key_irq(key_irq)
    );

    pot_scanner pot_scanner_i (
        .o2(o2), .reset(reset), .potgo(potgo), .line_tick(line_tick), .pot_sync(pot_sync),
        .pot0(pot0), .pot1(pot1), .pot2(pot2), .pot3(pot3),
        .pot4(pot4), .pot5(pot5), .pot6(pot6), .pot7(pot7),
        .allpot(allpot), .pot_dump(pot_dump)
    );

    pokey_read_mux read_mux_i (
        .o2(o2), .reset(reset), .rd(rd), .addr(addr),
        .pot0(pot0), .pot1(pot1), .pot2(pot2), .pot3(pot3),
        .pot4(pot4), .pot5(pot5), .pot6(pot6), .pot7(pot7),
        .allpot(allpot), .kbcode(kbcode), .key_down(key_down),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

endmodule

// ==== source/pokey_read_mux.sv ====
// POKEY output side, registered read data selected by register address
`timescale 1ns/1ps

module pokey_read_mux
    import pokey_pkg::*;
(
    input  logic       o2,
    input  logic       reset,
    input  logic       rd,
    input  logic [3:0] addr,
    input  logic [7:0] pot0,
    input  logic [7:0] pot1,
    input  logic [7:0] pot2,
    input  logic [7:0] pot3,
    input  logic [7:0] pot4,
    input  logic [7:0] pot5,
    input  logic [7:0] pot6,
    input  logic [7:0] pot7,
    input  logic [7:0] allpot,
    input  logic [7:0] kbcode,
    input  logic       key_down,
    output logic [7:0] rd_data,
    output logic       rd_valid    // one cycle after rd
);

    logic [7:0] sel_data;

    always_comb begin
        case (pokey_reg_e'(addr))
            POT0:    sel_data = pot0;
            POT1:    sel_data = pot1;
            POT2:    sel_data = pot2;
            POT3:    sel_data = pot3;
            POT4:    sel_data = pot4;
            POT5:    sel_data = pot5;
            POT6:    sel_data = pot6;
            POT7:    sel_data = pot7;
            ALLPOT:  sel_data = allpot;
            KBCODE:  sel_data = kbcode;
            SKSTAT:  sel_data = {5'b11111, ~key_down, 2'b11};   // bit 2 active low
            default: sel_data = 8'hFF;   // unmapped reads float high
        endcase
    end

    // data only moves on a read
    always_ff @(posedge o2) begin
        if (rd) begin
            rd_data <= sel_data;
        end
    end

    always_ff @(posedge o2) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;
        end
    end

endmodule

// ==== src.f ====
+incdir+common
common/pokey_pkg.sv
source/pokey_bus_regs.sv
keyscan/key_scanner.sv
potscan/pot_scanner.sv
source/pokey_read_mux.sv
source/pokey_io_top.sv
sim/pokey_io_assertions.sv
sim/pokey_io_tb.sv
